//--- rv_core_pkg.sv
package rv_core_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111
    } opcode_t;

    typedef enum logic [2:0] {
        fmt_r,
        fmt_i,
        fmt_s,
        fmt_b,
        fmt_u,
        fmt_j,
        fmt_none  // unknown opcode
    } inst_fmt_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    typedef struct packed {
        opcode_t                opcode;
        inst_fmt_t              fmt;
        logic [2:0]             funct3;
        logic [reg_addr_w-1:0]  rd;
        logic [reg_addr_w-1:0]  rs1;
        logic [reg_addr_w-1:0]  rs2;
        logic [xlen-1:0]        imm;
        alu_op_t                alu_op;
        logic                   reg_write;
    } decoded_inst_t;

    typedef struct packed {
        logic [xlen-1:0] addr;   // word aligned
        logic [xlen-1:0] wdata;  // already on its lanes
        logic [3:0]      wmask;
        logic            we;
    } dmem_req_t;

endpackage

//--- rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch #(
    parameter logic [rv_core_pkg::xlen-1:0] RESET_PC = 32'h8000_0000
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         jump_en,
    input  logic [rv_core_pkg::xlen-1:0] jump_target,
    output logic [rv_core_pkg::xlen-1:0] pc,
    output logic [rv_core_pkg::xlen-1:0] snpc
);
    import rv_core_pkg::*;

    logic [xlen-1:0] dnpc;

    assign snpc = pc + xlen'(4);
    assign dnpc = jump_en ? jump_target : snpc;  // redirect wins

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= dnpc;
        end
    end

endmodule

//--- rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
    input  logic [rv_core_pkg::xlen-1:0] inst,
    output rv_core_pkg::decoded_inst_t   dec
);
    import rv_core_pkg::*;

    opcode_t   opcode;
    inst_fmt_t fmt;
    logic      funct7_b5;

    assign opcode    = opcode_t'(inst[6:0]);
    assign funct7_b5 = inst[30];

    always_comb begin
        unique case (opcode)
            opc_op:                               fmt = fmt_r;
            opc_op_imm, opc_load, opc_jalr:       fmt = fmt_i;
            opc_store:                            fmt = fmt_s;
            opc_branch:                           fmt = fmt_b;
            opc_lui, opc_auipc:                   fmt = fmt_u;
            opc_jal:                              fmt = fmt_j;
            default:                              fmt = fmt_none;
        endcase
    end

    always_comb begin
        dec.opcode    = opcode;
        dec.fmt       = fmt;
        dec.funct3    = inst[14:12];
        dec.rd        = inst[11:7];
        dec.rs1       = inst[19:15];
        dec.rs2       = inst[24:20];
        dec.reg_write = (fmt == fmt_r) || (fmt == fmt_i) || (fmt == fmt_u) || (fmt == fmt_j);

        unique case (fmt)
            fmt_i:   dec.imm = {{20{inst[31]}}, inst[31:20]};
            fmt_s:   dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            fmt_b:   dec.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            fmt_u:   dec.imm = {inst[31:12], 12'b0};
            fmt_j:   dec.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: dec.imm = '0;
        endcase

        // only OP and OP_IMM pick from funct3, the rest add
        dec.alu_op = alu_add;
        if (opcode == opc_op || opcode == opc_op_imm) begin
            unique case (inst[14:12])
                3'b000:  dec.alu_op = (fmt == fmt_r && funct7_b5) ? alu_sub : alu_add;
                3'b001:  dec.alu_op = alu_sll;
                3'b010:  dec.alu_op = alu_slt;
                3'b011:  dec.alu_op = alu_sltu;
                3'b100:  dec.alu_op = alu_xor;
                3'b101:  dec.alu_op = funct7_b5 ? alu_sra : alu_srl;  // srai too
                3'b110:  dec.alu_op = alu_or;
                default: dec.alu_op = alu_and;
            endcase
        end
    end

endmodule

//--- rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic                               clk,
    input  logic                               we,
    input  logic [rv_core_pkg::reg_addr_w-1:0] waddr,
    input  logic [rv_core_pkg::xlen-1:0]       wdata,
    input  logic [rv_core_pkg::reg_addr_w-1:0] raddr1,
    input  logic [rv_core_pkg::reg_addr_w-1:0] raddr2,
    output logic [rv_core_pkg::xlen-1:0]       rdata1,
    output logic [rv_core_pkg::xlen-1:0]       rdata2
);

    logic [rv_core_pkg::xlen-1:0] regs [2**rv_core_pkg::reg_addr_w];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
    input  logic [rv_core_pkg::xlen-1:0] a,
    input  logic [rv_core_pkg::xlen-1:0] b,
    input  rv_core_pkg::alu_op_t         op,
    output logic [rv_core_pkg::xlen-1:0] result
);
    import rv_core_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        unique case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = xlen'($signed(a) < $signed(b));
            alu_sltu: result = xlen'(a < b);
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $unsigned($signed(a) >>> shamt);
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

//--- rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
    input  rv_core_pkg::decoded_inst_t   dec,
    input  logic [rv_core_pkg::xlen-1:0] src1,
    input  logic [rv_core_pkg::xlen-1:0] src2,
    input  logic [rv_core_pkg::xlen-1:0] pc,
    output logic [rv_core_pkg::xlen-1:0] alu_result,
    output logic                         jump_en,
    output logic [rv_core_pkg::xlen-1:0] jump_target
);
    import rv_core_pkg::*;

    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic            branch_taken;

    always_comb begin
        alu_a = src1;
        alu_b = dec.imm;
        unique case (dec.fmt)
            fmt_r:        alu_b = src2;
            fmt_u:        alu_a = (dec.opcode == opc_lui) ? '0 : pc;
            fmt_b, fmt_j: alu_a = pc;  // pc relative target
            default:      ;
        endcase
    end

    rv_alu rv_alu_inst (
        .a      (alu_a),
        .b      (alu_b),
        .op     (dec.alu_op),
        .result (alu_result)
    );

    always_comb begin
        unique case (dec.funct3)
            3'b000:  branch_taken = (src1 == src2);
            3'b001:  branch_taken = (src1 != src2);
            3'b100:  branch_taken = ($signed(src1) < $signed(src2));
            3'b101:  branch_taken = ($signed(src1) >= $signed(src2));
            3'b110:  branch_taken = (src1 < src2);
            3'b111:  branch_taken = (src1 >= src2);
            default: branch_taken = 1'b0;
        endcase
    end

    assign jump_en = (dec.opcode == opc_jal) || (dec.opcode == opc_jalr)
                     || ((dec.opcode == opc_branch) && branch_taken);

    assign jump_target = (dec.opcode == opc_jalr) ? {alu_result[xlen-1:1], 1'b0}
                                                  : alu_result;

endmodule

//--- rv_lsu.sv
`timescale 1ns/1ps

module rv_lsu (
    input  rv_core_pkg::decoded_inst_t   dec,
    input  logic [rv_core_pkg::xlen-1:0] addr,
    input  logic [rv_core_pkg::xlen-1:0] store_data,
    output rv_core_pkg::dmem_req_t       dmem_req,
    input  logic [rv_core_pkg::xlen-1:0] dmem_rdata,
    output logic [rv_core_pkg::xlen-1:0] load_data
);
    import rv_core_pkg::*;

    logic [xlen-1:0] rdata_shift;

    always_comb begin
        dmem_req.addr = {addr[xlen-1:2], 2'b00};
        dmem_req.we   = (dec.opcode == opc_store);
        unique case (dec.funct3[1:0])
            2'b00: begin  // sb
                dmem_req.wdata = {4{store_data[7:0]}};
                dmem_req.wmask = 4'b0001 << addr[1:0];
            end
            2'b01: begin  // sh
                dmem_req.wdata = {2{store_data[15:0]}};
                dmem_req.wmask = 4'b0011 << {addr[1], 1'b0};
            end
            default: begin
                dmem_req.wdata = store_data;
                dmem_req.wmask = 4'b1111;
            end
        endcase
        if (!dmem_req.we) begin
            dmem_req.wmask = 4'b0000;
        end
    end

    // move addressed lane down to bit 0
    assign rdata_shift = dmem_rdata >> {addr[1:0], 3'b000};

    always_comb begin
        unique case (dec.funct3)
            3'b000:  load_data = {{24{rdata_shift[7]}}, rdata_shift[7:0]};
            3'b001:  load_data = {{16{rdata_shift[15]}}, rdata_shift[15:0]};
            3'b100:  load_data = {24'b0, rdata_shift[7:0]};
            3'b101:  load_data = {16'b0, rdata_shift[15:0]};
            default: load_data = dmem_rdata;  // lw
        endcase
    end

endmodule

//--- rv_core.sv
`timescale 1ns/1ps

module rv_core #(
    parameter logic [rv_core_pkg::xlen-1:0] RESET_PC = 32'h8000_0000
) (
    input  logic                         clk,
    input  logic                         reset,
    output logic [rv_core_pkg::xlen-1:0] imem_addr,
    input  logic [rv_core_pkg::xlen-1:0] imem_rdata,
    output rv_core_pkg::dmem_req_t       dmem_req,
    input  logic [rv_core_pkg::xlen-1:0] dmem_rdata
);
    import rv_core_pkg::*;

    decoded_inst_t   dec;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] snpc;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] load_data;
    logic [xlen-1:0] jump_target;
    logic            jump_en;
    logic [xlen-1:0] wb_data;
    logic            wb_en;

    rv_fetch #(
        .RESET_PC (RESET_PC)
    ) rv_fetch_inst (
        .clk         (clk),
        .reset       (reset),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .pc          (pc),
        .snpc        (snpc)
    );

    assign imem_addr = pc;

    rv_decode rv_decode_inst (
        .inst (imem_rdata),
        .dec  (dec)
    );

    // link value for jumps, memory for loads
    always_comb begin
        unique case (dec.opcode)
            opc_jal, opc_jalr: wb_data = snpc;
            opc_load:          wb_data = load_data;
            default:           wb_data = alu_result;
        endcase
    end

    assign wb_en = dec.reg_write && (dec.rd != '0);

    rv_regfile rv_regfile_inst (
        .clk    (clk),
        .we     (wb_en),
        .waddr  (dec.rd),
        .wdata  (wb_data),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (src1),
        .rdata2 (src2)
    );

    rv_execute rv_execute_inst (
        .dec         (dec),
        .src1        (src1),
        .src2        (src2),
        .pc          (pc),
        .alu_result  (alu_result),
        .jump_en     (jump_en),
        .jump_target (jump_target)
    );

    rv_lsu rv_lsu_inst (
        .dec        (dec),
        .addr       (alu_result),
        .store_data (src2),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .load_data  (load_data)
    );

endmodule

//--- rv_core_checker.sv
`timescale 1ns/1ps

module rv_core_checker #(
    parameter logic [31:0] RESET_PC = 32'h8000_0000
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [31:0]            imem_addr,
    input  rv_core_pkg::dmem_req_t dmem_req,
    input  logic [31:0]            end_pc,
    output logic                   done
);
    import rv_core_pkg::*;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  mask;
    } store_exp_t;

    store_exp_t expected [$];
    int         value_errors = 0;
    int         unexpected = 0;
    logic       reset_q = 1'b0;

    initial done = 1'b0;

    function automatic logic [31:0] lane_bits(input logic [3:0] m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    task automatic add_expected_store(input logic [31:0] addr, input logic [31:0] data,
                                      input logic [3:0] mask);
        store_exp_t e;
        e.addr = addr;
        e.data = data;
        e.mask = mask;
        expected.push_back(e);
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    always @(posedge clk) begin : watch
        store_exp_t e;
        reset_q <= reset;
        if (reset_q && !reset) begin
            compare("imem_addr", RESET_PC, imem_addr);  // first fetch after reset
        end
        if (!reset && dmem_req.we === 1'b1) begin
            if (expected.size() == 0) begin
                unexpected++;
                $display("unexpected store to %h at pc %h", dmem_req.addr, imem_addr);
            end else begin
                e = expected.pop_front();
                compare("dmem_req.addr", e.addr, dmem_req.addr);
                compare("dmem_req.wmask", 32'(e.mask), 32'(dmem_req.wmask));
                // only the enabled lanes carry data
                compare("dmem_req.wdata", e.data & lane_bits(e.mask),
                        dmem_req.wdata & lane_bits(e.mask));
            end
        end
        if (!reset && imem_addr === end_pc) begin
            done <= 1'b1;
        end
    end

    task automatic summarize(input bit timed_out, output int total);
        if (expected.size() != 0) begin
            $display("missing stores: %0d expected stores never appeared", expected.size());
        end
        total = value_errors + unexpected + expected.size() + int'(timed_out);
        $display("errors: %0d wrong value, %0d unexpected store, %0d missing store, %0d timeout",
                 value_errors, unexpected, expected.size(), int'(timed_out));
    endtask

endmodule

//--- tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;
    import rv_core_pkg::*;

    localparam logic [31:0] reset_pc = 32'h8000_0000;
    localparam logic [31:0] lcg_seed = 32'hd378f7f8;

    typedef struct packed {
        logic [31:0] inst;
        logic        has_store;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  mask;
    } prog_row_t;

    logic        clk;
    logic        reset;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    dmem_req_t   dmem_req;
    logic [31:0] dmem_rdata;
    logic [31:0] end_pc;
    logic        done;

    logic [31:0] imem [256];
    logic [31:0] dmem [64];
    prog_row_t   rows [$];
    int          slot = 0;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    rv_core #(
        .RESET_PC (reset_pc)
    ) rv_core_inst (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    rv_core_checker #(
        .RESET_PC (reset_pc)
    ) rv_core_checker_inst (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .dmem_req  (dmem_req),
        .end_pc    (end_pc),
        .done      (done)
    );

    // reads are combinational and writes land at the rising edge
    assign imem_rdata = imem[(imem_addr - reset_pc) >> 2];
    assign dmem_rdata = dmem[dmem_req.addr[7:2]];

    always @(posedge clk) begin
        if (!reset && dmem_req.we === 1'b1) begin
            for (int i = 0; i < 4; i++) begin
                if (dmem_req.wmask[i]) begin
                    dmem[dmem_req.addr[7:2]][8*i +: 8] <= dmem_req.wdata[8*i +: 8];
                end
            end
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
                                           input opcode_t opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
    endfunction

    // expected ALU result straight from the RV32I rules
    function automatic logic [31:0] ref_op(input int op, input int alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (op)
            0: return alt ? a - b : a + b;
            1: return a << b[4:0];
            2: return {31'b0, $signed(a) < $signed(b)};
            3: return {31'b0, a < b};
            4: return a ^ b;
            5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic bit branch_rule(input int f3, input logic [31:0] a, input logic [31:0] b);
        case (f3)
            0: return a == b;
            1: return a != b;
            4: return $signed(a) < $signed(b);
            5: return $signed(a) >= $signed(b);
            6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] cur_pc();
        return reset_pc + 32'(4 * rows.size());
    endfunction

    task automatic add_row(input logic [31:0] inst, input logic has_store,
                           input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] mask);
        prog_row_t r;
        r.inst      = inst;
        r.has_store = has_store;
        r.addr      = addr;
        r.data      = data;
        r.mask      = mask;
        rows.push_back(r);
    endtask

    task automatic add_inst(input logic [31:0] inst);
        add_row(inst, 1'b0, 32'h0, 32'h0, 4'h0);
    endtask

    task automatic load_const(input int rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = value + 32'h800;  // addi sign-extends the low part
        add_inst(u_word(hi[31:12], 5'(rd), opc_lui));
        add_inst(i_word(value[11:0], 5'(rd), 3'b000, 5'(rd), opc_op_imm));
    endtask

    task automatic store_and_expect(input int rs, input logic [31:0] value);
        logic [11:0] addr;
        addr = 12'((slot % 40) * 4);
        add_row(s_word(addr, 5'(rs), 5'd0, 3'b010), 1'b1, 32'(addr), value, 4'hf);
        slot++;
    endtask

    task automatic build_program();
        logic [31:0] rnd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] bval;
        logic [31:0] r;
        logic [31:0] keep;
        logic [31:0] word;
        logic [31:0] sx;
        logic [31:0] pc_here;
        logic [11:0] imm;
        logic [11:0] marker;
        logic [11:0] w;
        logic [3:0]  bm;
        int          f3;
        int          rs1;
        int          rs2;
        rnd = lcg_next(lcg_seed);
        a = rnd | 32'h8000_0000;  // x1 negative
        rnd = lcg_next(rnd);
        b = rnd & 32'h7fff_ffff;  // x2 positive
        load_const(1, a);
        load_const(2, b);
        for (int op = 0; op < 8; op++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 0 || op == 0 || op == 5) begin
                    add_inst(r_word(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, 3'(op), 5'd3));
                    store_and_expect(3, ref_op(op, alt, a, b));
                end
            end
        end
        for (int op = 2; op < 4; op++) begin  // compares again with operands swapped
            add_inst(r_word(7'h00, 5'd1, 5'd2, 3'(op), 5'd3));
            store_and_expect(3, ref_op(op, 0, b, a));
        end
        for (int op = 0; op < 8; op++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 0 || op == 5) begin
                    rnd = lcg_next(rnd);
                    if (op == 1 || op == 5) begin
                        imm  = {1'b0, 1'(alt), 5'b0, rnd[4:0]};
                        bval = {27'b0, rnd[4:0]};
                    end else begin
                        imm  = rnd[11:0];
                        bval = {{20{rnd[11]}}, rnd[11:0]};
                    end
                    add_inst(i_word(imm, 5'd1, 3'(op), 5'd3, opc_op_imm));
                    store_and_expect(3, ref_op(op, alt, a, bval));
                end
            end
        end
        rnd = lcg_next(rnd);
        add_inst(u_word(rnd[31:12], 5'd3, opc_lui));
        store_and_expect(3, {rnd[31:12], 12'h000});
        rnd = lcg_next(rnd);
        pc_here = cur_pc();
        add_inst(u_word(rnd[31:12], 5'd3, opc_auipc));
        store_and_expect(3, pc_here + {rnd[31:12], 12'h000});
        // jal over one store
        pc_here = cur_pc();
        add_inst(j_word(21'd8, 5'd5));
        add_inst(s_word(12'h0, 5'd1, 5'd0, 3'b010));
        store_and_expect(5, pc_here + 4);
        // odd jalr offset drops bit 0 of the target
        pc_here = cur_pc();
        add_inst(u_word(20'h0, 5'd6, opc_auipc));
        add_inst(i_word(12'd13, 5'd6, 3'b000, 5'd7, opc_jalr));
        add_inst(s_word(12'h0, 5'd1, 5'd0, 3'b010));
        store_and_expect(7, pc_here + 8);
        for (int i = 0; i < 6; i++) begin
            f3 = (i < 2) ? i : i + 2;
            for (int p = 0; p < 3; p++) begin
                rs1 = (p == 1) ? 2 : 1;
                rs2 = (p == 0) ? 2 : 1;
                marker = 12'(256 + 3 * i + p);
                add_inst(i_word(marker, 5'd0, 3'b000, 5'd8, opc_op_imm));
                add_inst(b_word(13'd8, 5'(rs2), 5'(rs1), 3'(f3)));
                if (branch_rule(f3, (rs1 == 1) ? a : b, (rs2 == 1) ? a : b)) begin
                    add_inst(s_word(12'h0, 5'd8, 5'd0, 3'b010));  // skipped
                end else begin
                    store_and_expect(8, 32'(marker));
                end
            end
        end
        // sb then sh at every lane and reloaded signed and unsigned
        for (int sz = 0; sz < 2; sz++) begin
            w = 12'(192 + 4 * sz);
            add_row(s_word(w, 5'd1, 5'd0, 3'b010), 1'b1, 32'(w), a, 4'hf);
            word = a;
            keep = (sz == 0) ? 32'h0000_00ff : 32'h0000_ffff;
            for (int off = 0; off < 4; off += sz + 1) begin
                rnd = lcg_next(rnd);
                r = rnd;
                r[(8 << sz) - 1] = 1'((off >> sz) & 1);  // both signs
                sx = (sz == 0) ? {{24{r[7]}}, r[7:0]} : {{16{r[15]}}, r[15:0]};
                bm = (sz == 0) ? 4'b0001 << off : 4'b0011 << off;
                load_const(9, r);
                add_row(s_word(w + 12'(off), 5'd9, 5'd0, 3'(sz)), 1'b1, 32'(w),
                        (r & keep) << (8 * off), bm);
                word = (word & ~(keep << (8 * off))) | ((r & keep) << (8 * off));
                add_inst(i_word(w + 12'(off), 5'd0, 3'(sz), 5'd3, opc_load));
                store_and_expect(3, sx);
                add_inst(i_word(w + 12'(off), 5'd0, 3'(4 + sz), 5'd4, opc_load));
                store_and_expect(4, r & keep);
            end
            add_inst(i_word(w, 5'd0, 3'b010, 5'd3, opc_load));
            store_and_expect(3, word);
        end
        add_inst(i_word(12'h0, 5'd1, 3'b000, 5'd0, opc_op_imm));  // x0 stays zero
        store_and_expect(0, 32'h0);
        end_pc = cur_pc();
        add_inst(j_word(21'd0, 5'd0));
    endtask

    initial begin : main
        int cycles;
        int limit;
        int total;
        reset = 1'b1;
        end_pc = 32'h0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = i_word(12'(i), 5'd0, 3'b000, 5'd0, opc_op_imm);  // nop tagged with index
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] = 32'hd00d_0000 | 32'(i);
        end
        build_program();
        foreach (rows[i]) begin
            imem[i] = rows[i].inst;
            if (rows[i].has_store) begin
                rv_core_checker_inst.add_expected_store(rows[i].addr, rows[i].data,
                                                        rows[i].mask);
            end
        end
        limit = 2 * rows.size() + 20;
        cycles = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (!done && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            $display("timeout: program did not reach its final jump within %0d cycles", limit);
        end
        rv_core_checker_inst.summarize(!done, total);
        if (total == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
rv_core_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_alu.sv
rv_execute.sv
rv_lsu.sv
rv_core.sv
rv_core_checker.sv
tb_rv_core.sv
